// File: design/cam_addr_compare.sv
// EPN comparator with page-size masking and the exclusion-bit rule
module cam_addr_compare #(
   parameter int have_xbit = 1
) (
   input  cam_match_pkg::epn_t addr_in,
   input  cam_match_pkg::epn_t entry_epn,
   input  logic [0:1]          addr_enable,
   input  logic                entry_xbit,
   cam_pgsize_if.sink          pg,
   output logic                addr_match
);
   import cam_match_pkg::*;

   epn_t    epn_eq;
   logic    hi_match;
   logic    mid_match;
   pgmask_t seg_match;
   pgmask_t xbit_match;

   // Bitwise equality of lookup address and stored EPN
   assign epn_eq = ~(addr_in ^ entry_epn);

   // Upper bits can be left out of the compare by addr_enable bit 1
   assign hi_match = (&epn_eq[0:epn_hi_last]) | ~addr_enable[1];

   assign mid_match = &epn_eq[epn_hi_last+1:epn_mid_last];

   generate
      for (genvar i = 0; i < num_pgsizes; i++)
      begin : g_size
         // Each segment runs from this size's boundary to the next one
         localparam int next_i    = (i + 1 < num_pgsizes) ? i + 1 : i;
         localparam int seg_first = pg_lo_bit[i];
         localparam int seg_last  = (i + 1 < num_pgsizes) ? pg_lo_bit[next_i] - 1 : epn_w - 1;

         // Segment lies inside the page offset once the page is this big
         assign seg_match[i] = (&epn_eq[seg_first:seg_last]) | pg.size_gte[i];

         if (have_xbit != 0)
         begin : g_xbit
            // With xbit set the entry excludes every address whose offset bits
            // are a subset of the EPN bits, including the EPN itself
            assign xbit_match[i] = ~entry_xbit |
                                   ~pg.size_eq[i] |
                                   (|(addr_in[seg_first:epn_w-1] &
                                      ~entry_epn[seg_first:epn_w-1]));
         end
         else
         begin : g_no_xbit
            assign xbit_match[i] = 1'b1;
         end
      end
   endgenerate

   // addr_enable bit 0 low turns the whole address compare off
   assign addr_match = (hi_match &
                        mid_match &
                        (&seg_match) &
                        (&xbit_match)) |
                       ~addr_enable[0];

endmodule

// File: design/cam_attr_compare.sv
// Attribute comparator for size, class, state, thread and PID fields of one entry
module cam_attr_compare (
   input  cam_match_pkg::size_t  comp_pgsize,
   input  cam_match_pkg::size_t  entry_size,
   input  logic                  pgsize_enable,
   input  logic [0:1]            comp_class,
   input  logic [0:1]            entry_class,
   input  logic [0:2]            class_enable,
   input  logic [0:1]            comp_extclass,
   input  logic [0:1]            entry_extclass,
   input  logic [0:1]            extclass_enable,
   input  logic [0:1]            comp_state,
   input  logic                  entry_hv,
   input  logic                  entry_ds,
   input  logic [0:1]            state_enable,
   input  cam_match_pkg::thdid_t comp_thdid,
   input  cam_match_pkg::thdid_t entry_thdid,
   input  logic [0:1]            thdid_enable,
   input  cam_match_pkg::pid_t   comp_pid,
   input  cam_match_pkg::pid_t   entry_pid,
   input  logic                  pid_enable,
   input  logic                  comp_invalidate,
   output logic                  attr_match
);

   logic exempt;
   logic pgsize_match;
   logic class_match;
   logic extclass_match;
   logic state_match;
   logic thdid_match;
   logic pid_match;

   // Unprotected entries skip the PID, full class and full thread compares
   // Protection (extclass bit 1) and invalidates both cancel the exemption
   assign exempt = ~entry_extclass[1] & ~comp_invalidate;

   assign pgsize_match = (comp_pgsize == entry_size) | ~pgsize_enable;

   assign class_match = ((comp_class[0] == entry_class[0]) | ~class_enable[0]) &
                        ((comp_class[1] == entry_class[1]) | ~class_enable[1]) &
                        ((comp_class == entry_class) | ~class_enable[2] | exempt);

   assign extclass_match = ((comp_extclass[0] == entry_extclass[0]) | ~extclass_enable[0]) &
                           ((comp_extclass[1] == entry_extclass[1]) | ~extclass_enable[1]);

   // State bit 0 is the hypervisor bit and state bit 1 the data-space bit
   assign state_match = ((comp_state[0] == entry_hv) | ~state_enable[0]) &
                        ((comp_state[1] == entry_ds) | ~state_enable[1]);

   // Enable bit 0 asks for a shared thread, enable bit 1 for the same thread set
   assign thdid_match = ((|(comp_thdid & entry_thdid)) | ~thdid_enable[0]) &
                        ((comp_thdid == entry_thdid) | ~thdid_enable[1] | exempt);

   assign pid_match = (comp_pid == entry_pid) | exempt | ~pid_enable;

   assign attr_match = pgsize_match &
                       class_match &
                       extclass_match &
                       state_match &
                       thdid_match &
                       pid_match;

endmodule

// File: design/cam_match_pkg.sv
// Translation CAM entry compare package with field widths, size codes and EPN bounds
package cam_match_pkg;

   // Field widths
   localparam int epn_w       = 52;
   localparam int size_w      = 3;
   localparam int num_pgsizes = 4;
   localparam int pid_w       = 8;
   localparam int thdid_w     = 4;

   // Bit 0 is the most significant bit of every field
   typedef logic [0:epn_w-1]       epn_t;
   typedef logic [0:size_w-1]      size_t;
   typedef logic [0:pid_w-1]       pid_t;
   typedef logic [0:thdid_w-1]     thdid_t;

   // One bit per page size above 4K, largest first
   //    0 = 1G, 1 = 16M, 2 = 1M, 3 = 64K
   typedef logic [0:num_pgsizes-1] pgmask_t;

   // Page-size codes of a stored entry
   // Every code not listed here means a 4K page
   localparam size_t size_1g  = 3'b110;
   localparam size_t size_16m = 3'b111;
   localparam size_t size_1m  = 3'b101;
   localparam size_t size_64k = 3'b011;

   // The upper segment can be masked off by addr_enable bit 1
   localparam int epn_hi_last  = 30;

   // Bits after epn_hi_last up to this one are compared for every size
   localparam int epn_mid_last = 33;

   // First EPN bit that falls inside the page offset of each size
   // Indexed like pgmask_t, so entry 0 belongs to 1G
   localparam int pg_lo_bit [0:num_pgsizes-1] = '{34, 40, 44, 48};

endpackage

// File: design/cam_matchline.sv
// Match line of one translation CAM entry, combining address, attributes and valid
module cam_matchline #(
   parameter int have_xbit    = 1,
   parameter int have_cmpmask = 1
) (
   input  cam_match_pkg::epn_t    addr_in,
   input  logic [0:1]             addr_enable,
   input  cam_match_pkg::size_t   comp_pgsize,
   input  logic                   pgsize_enable,
   input  cam_match_pkg::size_t   entry_size,
   input  cam_match_pkg::pgmask_t entry_cmpmask,
   input  logic                   entry_xbit,
   input  cam_match_pkg::pgmask_t entry_xbitmask,
   input  cam_match_pkg::epn_t    entry_epn,
   input  logic [0:1]             comp_class,
   input  logic [0:1]             entry_class,
   input  logic [0:2]             class_enable,
   input  logic [0:1]             comp_extclass,
   input  logic [0:1]             entry_extclass,
   input  logic [0:1]             extclass_enable,
   input  logic [0:1]             comp_state,
   input  logic                   entry_hv,
   input  logic                   entry_ds,
   input  logic [0:1]             state_enable,
   input  cam_match_pkg::thdid_t  entry_thdid,
   input  cam_match_pkg::thdid_t  comp_thdid,
   input  logic [0:1]             thdid_enable,
   input  cam_match_pkg::pid_t    entry_pid,
   input  cam_match_pkg::pid_t    comp_pid,
   input  logic                   pid_enable,
   input  logic                   entry_v,
   input  logic                   comp_invalidate,
   output logic                   match
);

   logic addr_match;
   logic attr_match;

   cam_pgsize_if pg_if ();

   cam_pgsize_decode #(
      .have_cmpmask (have_cmpmask)
   ) pgsize_decode_i (
      .entry_size     (entry_size),
      .entry_cmpmask  (entry_cmpmask),
      .entry_xbitmask (entry_xbitmask),
      .pg             (pg_if.src)
   );

   cam_addr_compare #(
      .have_xbit (have_xbit)
   ) addr_compare_i (
      .addr_in     (addr_in),
      .entry_epn   (entry_epn),
      .addr_enable (addr_enable),
      .entry_xbit  (entry_xbit),
      .pg          (pg_if.sink),
      .addr_match  (addr_match)
   );

   cam_attr_compare attr_compare_i (
      .comp_pgsize     (comp_pgsize),
      .entry_size      (entry_size),
      .pgsize_enable   (pgsize_enable),
      .comp_class      (comp_class),
      .entry_class     (entry_class),
      .class_enable    (class_enable),
      .comp_extclass   (comp_extclass),
      .entry_extclass  (entry_extclass),
      .extclass_enable (extclass_enable),
      .comp_state      (comp_state),
      .entry_hv        (entry_hv),
      .entry_ds        (entry_ds),
      .state_enable    (state_enable),
      .comp_thdid      (comp_thdid),
      .entry_thdid     (entry_thdid),
      .thdid_enable    (thdid_enable),
      .comp_pid        (comp_pid),
      .entry_pid       (entry_pid),
      .pid_enable      (pid_enable),
      .comp_invalidate (comp_invalidate),
      .attr_match      (attr_match)
   );

   // An invalid entry never matches
   assign match = addr_match & attr_match & entry_v;

endmodule

// File: design/cam_pgsize_decode.sv
// Page-size decoder that builds size-at-least and size-equal masks for one entry
module cam_pgsize_decode #(
   parameter int have_cmpmask = 1
) (
   input  cam_match_pkg::size_t   entry_size,
   input  cam_match_pkg::pgmask_t entry_cmpmask,
   input  cam_match_pkg::pgmask_t entry_xbitmask,
   cam_pgsize_if.src              pg
);
   import cam_match_pkg::*;

   generate
      if (have_cmpmask == 0)
      begin : g_decode
         pgmask_t size_eq;
         pgmask_t size_gte;

         always_comb
         begin
            // Exact code match per size, 4K sets no bit at all
            size_eq[0] = (entry_size == size_1g);
            size_eq[1] = (entry_size == size_16m);
            size_eq[2] = (entry_size == size_1m);
            size_eq[3] = (entry_size == size_64k);

            // A page at least as big as a larger size is also at least as big as
            // every smaller one, so the chain runs from 1G down to 64K
            size_gte[0] = size_eq[0];
            for (int i = 1; i < num_pgsizes; i++)
            begin
               size_gte[i] = size_eq[i] | size_gte[i-1];
            end
         end

         assign pg.size_eq  = size_eq;
         assign pg.size_gte = size_gte;
      end
      else
      begin : g_cmpmask
         // Masks are precomputed when the entry is written
         // A cmpmask bit of 1 means the segment of that size takes part in the compare
         assign pg.size_gte = ~entry_cmpmask;
         assign pg.size_eq  = entry_xbitmask;
      end
   endgenerate

endmodule

// File: design/cam_pgsize_if.sv
// Page-size mask bundle from the size decoder to the EPN comparator
interface cam_pgsize_if;
   import cam_match_pkg::*;

   // Entry page is at least as large as each size
   pgmask_t size_gte;

   // Entry page is exactly each size, used by the exclusion rule
   pgmask_t size_eq;

   modport src
   (
      output size_gte,
      output size_eq
   );

   modport sink
   (
      input size_gte,
      input size_eq
   );

endinterface

// File: include/tb_cam_model.svh
// Reference model and typed checkers for the CAM entry match line
`ifndef TB_CAM_MODEL_SVH
`define TB_CAM_MODEL_SVH

// Position of a size code in pgmask_t order, num_pgsizes for a 4K page
function automatic int size_rank(input cam_match_pkg::size_t code);
   case (code)
      cam_match_pkg::size_1g:  return 0;
      cam_match_pkg::size_16m: return 1;
      cam_match_pkg::size_1m:  return 2;
      cam_match_pkg::size_64k: return 3;
      default:                 return cam_match_pkg::num_pgsizes;
   endcase
endfunction

// Address rule with the exclusion bit enabled, taken straight from the size code
function automatic logic model_addr_match(
   input cam_match_pkg::epn_t  addr_in,
   input cam_match_pkg::epn_t  entry_epn,
   input logic [0:1]           addr_enable,
   input cam_match_pkg::size_t entry_size,
   input logic                 entry_xbit
);
   int   rank;
   int   first;
   logic ok;
   logic excl_hit;

   rank  = size_rank(entry_size);
   first = (rank < cam_match_pkg::num_pgsizes) ?
           cam_match_pkg::pg_lo_bit[rank] : cam_match_pkg::epn_w;
   ok       = 1'b1;
   excl_hit = 1'b0;
   for (int j = 0; j < first; j++)
   begin
      if (addr_in[j] !== entry_epn[j] && (j > cam_match_pkg::epn_hi_last || addr_enable[1]))
         ok = 1'b0;
   end
   // Only the exact size of the entry carries the exclusion rule
   if (entry_xbit && first < cam_match_pkg::epn_w)
   begin
      for (int j = first; j < cam_match_pkg::epn_w; j++)
         excl_hit |= addr_in[j] & ~entry_epn[j];
      ok &= excl_hit;
   end
   return ok | ~addr_enable[0];
endfunction

// Stops the run on the first mismatch of a one-bit result
task automatic check_match(input string name, input logic actual, input logic expected);
   if (actual !== expected)
   begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
   end
endtask

// Checks that the precomputed masks belong to the size code under test
task automatic check_size(
   input cam_match_pkg::size_t   code,
   input cam_match_pkg::pgmask_t cmpmask,
   input cam_match_pkg::pgmask_t xbitmask
);
   cam_match_pkg::pgmask_t exp_cmp;
   cam_match_pkg::pgmask_t exp_xbit;

   for (int i = 0; i < cam_match_pkg::num_pgsizes; i++)
   begin
      exp_cmp[i]  = ~(size_rank(code) <= i);
      exp_xbit[i] = (size_rank(code) == i);
   end
   if (cmpmask !== exp_cmp || xbitmask !== exp_xbit)
   begin
      $display("Fail at %0t: entry_cmpmask/entry_xbitmask are %b/%b, expected %b/%b",
               $time, cmpmask, xbitmask, exp_cmp, exp_xbit);
      $display("TEST FAILED");
      $fatal(1);
   end
endtask

`endif

// File: dv/tb_cam_matchline.sv
// Testbench for the CAM entry match line with directed address and attribute tests
module tb_cam_matchline;
   import cam_match_pkg::*;

   `include "tb_cam_model.svh"

   localparam int reset_cycles = 4;
   localparam int max_cycles   = 2000;

   logic       clk;
   logic       arst_n;
   integer     seed;

   epn_t       addr_in;
   logic [0:1] addr_enable;
   size_t      comp_pgsize;
   logic       pgsize_enable;
   size_t      entry_size;
   pgmask_t    entry_cmpmask;
   logic       entry_xbit;
   pgmask_t    entry_xbitmask;
   epn_t       entry_epn;
   logic [0:1] comp_class;
   logic [0:1] entry_class;
   logic [0:2] class_enable;
   logic [0:1] comp_extclass;
   logic [0:1] entry_extclass;
   logic [0:1] extclass_enable;
   logic [0:1] comp_state;
   logic       entry_hv;
   logic       entry_ds;
   logic [0:1] state_enable;
   thdid_t     entry_thdid;
   thdid_t     comp_thdid;
   logic [0:1] thdid_enable;
   pid_t       entry_pid;
   pid_t       comp_pid;
   logic       pid_enable;
   logic       entry_v;
   logic       comp_invalidate;
   logic       match;

   // Page sizes ordered from largest to 4K and indexed by size rank
   size_t sizes [0:4] = '{size_1g, size_16m, size_1m, size_64k, 3'b000};

   // EPN segments as upper, middle and then one per page size
   int seg_first [0:5] = '{0, 31, 34, 40, 44, 48};
   int seg_last  [0:5] = '{30, 33, 39, 43, 47, 51};

   cam_matchline cam_matchline_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

   initial
   begin
      for (int n = 0; n < max_cycles; n++)
      begin
         @(posedge clk);
      end
      $display("Timeout: the test sequence did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1);
   end

   function automatic int pick_bit(input int lo, input int hi);
      return lo + ($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   // Full match of a random entry with every enable set and no exemption
   task automatic load_entry(input size_t code);
      logic [63:0] raw;

      raw = {$random(seed), $random(seed)};
      entry_epn = raw[51:0];
      addr_in = entry_epn;
      addr_enable = 2'b11;
      entry_size = code;
      comp_pgsize = code;
      pgsize_enable = 1'b1;
      entry_xbit = 1'b0;
      case (code)
         size_1g:  {entry_cmpmask, entry_xbitmask} = 8'b0000_1000;
         size_16m: {entry_cmpmask, entry_xbitmask} = 8'b1000_0100;
         size_1m:  {entry_cmpmask, entry_xbitmask} = 8'b1100_0010;
         size_64k: {entry_cmpmask, entry_xbitmask} = 8'b1110_0001;
         default:  {entry_cmpmask, entry_xbitmask} = 8'b1111_0000;
      endcase
      check_size(code, entry_cmpmask, entry_xbitmask);
      entry_class = $random(seed);
      comp_class = entry_class;
      class_enable = 3'b111;
      entry_extclass = {1'b0, 1'b1} | 2'($random(seed));
      comp_extclass = entry_extclass;
      extclass_enable = 2'b11;
      {entry_hv, entry_ds} = $random(seed);
      comp_state = {entry_hv, entry_ds};
      state_enable = 2'b11;
      entry_thdid = $random(seed);
      if (entry_thdid == '0)
         entry_thdid = 4'b1000;
      comp_thdid = entry_thdid;
      thdid_enable = 2'b11;
      entry_pid = $random(seed);
      comp_pid = entry_pid;
      pid_enable = 1'b1;
      comp_invalidate = 1'b0;
      entry_v = 1'b1;
   endtask

   task automatic expect_match(input string what, input logic expected);
      @(posedge clk);
      check_match($sformatf("match (%s)", what), match, expected);
   endtask

   task automatic wait_reset_release;
      int n;

      n = 0;
      while (arst_n !== 1'b1 && n < 4 * reset_cycles)
      begin
         @(negedge clk);
         n++;
      end
      if (arst_n !== 1'b1)
      begin
         $display("Timeout: reset was never released");
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic test_exact_address;
      int   pos;
      logic exp;

      for (int s = 0; s < 5; s++)
      begin
         @(negedge clk);
         load_entry(sizes[s]);
         expect_match("equal EPN", 1'b1);
         for (int seg = 0; seg < 6; seg++)
         begin
            @(negedge clk);
            load_entry(sizes[s]);
            pos = pick_bit(seg_first[seg], seg_last[seg]);
            addr_in[pos] = ~addr_in[pos];
            // A page segment drops out of the compare once the page covers it
            exp = (seg >= 2) && (s <= seg - 2);
            check_match("model_addr_match",
                        model_addr_match(addr_in, entry_epn, addr_enable, entry_size, entry_xbit),
                        exp);
            expect_match($sformatf("size rank %0d, bit %0d flipped", s, pos), exp);
         end
      end
   endtask

   task automatic test_address_enables;
      int pos;

      @(negedge clk);
      load_entry(3'b000);
      pos = pick_bit(0, epn_hi_last);
      addr_in[pos] = ~addr_in[pos];
      expect_match("upper bit differs, all enables", 1'b0);
      @(negedge clk);
      addr_enable = 2'b10;
      expect_match("upper bit differs, addr_enable bit 1 low", 1'b1);
      @(negedge clk);
      addr_in = ~entry_epn;
      addr_enable = 2'b01;
      expect_match("any EPN, addr_enable bit 0 low", 1'b1);
   endtask

   task automatic test_exclusion;
      @(negedge clk);
      load_entry(size_1m);
      entry_xbit = 1'b1;
      entry_epn[44:51] = 8'b01100101;
      addr_in = entry_epn;
      expect_match("xbit, address equals EPN", 1'b0);
      @(negedge clk);
      addr_in[44:51] = 8'b01100111;
      expect_match("xbit, address has extra 1", 1'b1);
      @(negedge clk);
      addr_in[44:51] = 8'b01000101;
      expect_match("xbit, address is subset", 1'b0);
      @(negedge clk);
      entry_xbit = 1'b0;
      expect_match("subset without xbit", 1'b1);
   endtask

   task automatic test_attributes;
      @(negedge clk);
      load_entry(size_64k);
      comp_pgsize = size_1m;
      expect_match("size differs", 1'b0);
      @(negedge clk);
      pgsize_enable = 1'b0;
      expect_match("size differs, disabled", 1'b1);

      @(negedge clk);
      load_entry(size_64k);
      comp_class[0] = ~entry_class[0];
      expect_match("class differs", 1'b0);
      @(negedge clk);
      class_enable = 3'b010;
      expect_match("class differs, disabled", 1'b1);
      @(negedge clk);
      comp_class[1] = ~entry_class[1];
      expect_match("class bit 1 differs", 1'b0);

      @(negedge clk);
      load_entry(size_64k);
      comp_extclass[0] = ~entry_extclass[0];
      expect_match("extclass differs", 1'b0);
      @(negedge clk);
      extclass_enable = 2'b01;
      expect_match("extclass differs, disabled", 1'b1);
      @(negedge clk);
      comp_extclass[1] = ~entry_extclass[1];
      expect_match("extclass bit 1 differs", 1'b0);

      @(negedge clk);
      load_entry(size_64k);
      comp_state[0] = ~entry_hv;
      expect_match("hv differs", 1'b0);
      @(negedge clk);
      state_enable = 2'b01;
      expect_match("hv differs, disabled", 1'b1);
      @(negedge clk);
      comp_state[1] = ~entry_ds;
      expect_match("ds differs", 1'b0);

      @(negedge clk);
      load_entry(size_64k);
      entry_thdid = 4'b0011;
      comp_thdid = 4'b0110;
      expect_match("thread set differs", 1'b0);
      @(negedge clk);
      thdid_enable = 2'b10;
      expect_match("thread set differs, shared bit", 1'b1);
      @(negedge clk);
      comp_thdid = 4'b1100;
      expect_match("no shared thread", 1'b0);
      @(negedge clk);
      thdid_enable = 2'b00;
      expect_match("no shared thread, disabled", 1'b1);

      @(negedge clk);
      load_entry(size_64k);
      comp_pid = ~entry_pid;
      expect_match("PID differs", 1'b0);
      @(negedge clk);
      pid_enable = 1'b0;
      expect_match("PID differs, disabled", 1'b1);
   endtask

   task automatic test_exemption;
      @(negedge clk);
      load_entry(size_16m);
      entry_extclass[1] = 1'b0;
      comp_extclass[1] = 1'b0;
      comp_pid = ~entry_pid;
      comp_class = ~entry_class;
      class_enable = 3'b001;
      expect_match("unprotected entry, PID and class differ", 1'b1);
      @(negedge clk);
      comp_invalidate = 1'b1;
      expect_match("same stimulus during invalidate", 1'b0);
      @(negedge clk);
      comp_invalidate = 1'b0;
      entry_extclass[1] = 1'b1;
      comp_extclass[1] = 1'b1;
      expect_match("same stimulus, protected entry", 1'b0);
   endtask

   task automatic test_valid;
      @(negedge clk);
      load_entry(size_1g);
      entry_v = 1'b0;
      expect_match("invalid entry", 1'b0);
   endtask

   initial
   begin
      seed = 32'hebdcc5f4;
      load_entry(3'b000);
      entry_v = 1'b0;
      wait_reset_release();
      test_exact_address();
      test_address_enables();
      test_exclusion();
      test_attributes();
      test_exemption();
      test_valid();
      $display("TEST OK");
      $finish;
   end

endmodule

// File: tb.f
+incdir+include
design/cam_match_pkg.sv
design/cam_pgsize_if.sv
design/cam_pgsize_decode.sv
design/cam_addr_compare.sv
design/cam_attr_compare.sv
design/cam_matchline.sv
dv/tb_cam_matchline.sv
